// ==== design/frontend_pkg.sv ====
/* Shared widths and counters of the fetch bus and the prefetch queue.
   Imported by every stage of the instruction fetch front end */

`default_nettype none

package frontend_pkg;

	// ----------------------------------------------------------------------
	// Memory bus

	// Byte address on the fetch bus, always word aligned when issued
	typedef logic [31:0] addr_t;

	// One fetched data word, two instruction parcels wide
	typedef logic [31:0] word_t;

	// Per-halfword valid or error mask of a word
	// Bit 0 is the lower halfword and bit 1 the upper halfword
	typedef logic [1:0] hw_mask_t;

	// ----------------------------------------------------------------------
	// Counters

	// Number of valid halfwords in the assembly buffer, 0 to 3
	typedef logic [1:0] level_t;

	// Number of accepted fetches whose data has not yet come back, 0 to 2
	typedef logic [1:0] pending_t;

	// First fetch address after reset
	localparam addr_t DEFAULT_RESET_VECTOR = 32'h0000_0100;

	// Two entries is the smallest queue that keeps full fetch throughput
	localparam int DEFAULT_QUEUE_DEPTH = 2;

endpackage

`default_nettype wire

// ==== design/rv_isa_pkg.sv ====
/* RISC-V instruction parcel definitions used by the instruction assembly
   stage and by decode-side models */

`default_nettype none

package rv_isa_pkg;

	// One 16-bit instruction parcel
	typedef logic [15:0] halfword_t;

	// Current instruction register, two parcels with the older one in bits 15:0
	typedef logic [31:0] cir_t;

	// Low two bits of a parcel that start a 32-bit instruction
	// Every other value starts a 16-bit compressed instruction
	localparam logic [1:0] LEN32_CODE = 2'b11;

endpackage

`default_nettype wire

// ==== design/fetch_request.sv ====
/* First front-end stage. Issues word fetch addresses, follows jumps and
   counts fetches in flight so that flushed data can be discarded */

`default_nettype none

module fetch_request #(
	parameter frontend_pkg::addr_t RESET_VECTOR = frontend_pkg::DEFAULT_RESET_VECTOR
) (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire                           mem_addr_rdy,
	input  wire                           mem_data_vld,
	input  wire frontend_pkg::addr_t      jump_target,
	input  wire                           jump_target_vld,
	input  wire                           queue_full,
	input  wire                           queue_almost_full,
	output frontend_pkg::addr_t           mem_addr,
	output logic                          mem_addr_vld,
	output logic                          jump_target_rdy,
	output logic                          jump_now,
	output logic                          data_live,
	output frontend_pkg::hw_mask_t        data_hwvld
);

	import frontend_pkg::*;

	// Next word to fetch, runs ahead of the instruction stream
	addr_t    fetch_addr;
	logic     addr_hold;
	logic     reset_holdoff;
	logic     addr_req;
	logic     addr_accept;
	logic     inflight_full;
	logic     fetch_stall;
	pending_t pending;
	pending_t flush_ctr;
	// Valid halfwords of the word in address phase and of the next live data word
	hw_mask_t aph_hwvld;
	hw_mask_t dph_hwvld;

	// ----------------------------------------------------------------------
	// Address phase

	assign jump_target_rdy = !addr_hold;
	assign jump_now = jump_target_vld && jump_target_rdy;
	assign addr_accept = mem_addr_vld && mem_addr_rdy;

	// Pending is registered, so the queue must absorb up to two returning words
	assign inflight_full = pending > 2'd1;
	assign fetch_stall = queue_full || (queue_almost_full && pending != 2'd0) || inflight_full;

	// A held address wins over everything, then a jump goes out at once
	// if the bus has room for one more fetch
	always_comb begin
		mem_addr = fetch_addr;
		addr_req = 1'b1;
		if (addr_hold) begin
			mem_addr = fetch_addr;
		end else if (jump_target_vld && !inflight_full) begin
			mem_addr = {jump_target[31:2], 2'b00};
		end else if (jump_target_vld || fetch_stall) begin
			addr_req = 1'b0;
		end
	end

	// Nothing is requested in the first cycle out of reset
	assign mem_addr_vld = addr_req && !reset_holdoff;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reset_holdoff <= 1'b1;
			addr_hold <= 1'b0;
			fetch_addr <= RESET_VECTOR;
		end else begin
			reset_holdoff <= 1'b0;
			addr_hold <= mem_addr_vld && !mem_addr_rdy;
			if (jump_now) begin
				// Skip past the target word when it was accepted in this same cycle
				fetch_addr <= {jump_target[31:2] + 30'(addr_accept), 2'b00};
			end else if (addr_accept) begin
				fetch_addr <= fetch_addr + 32'd4;
			end
		end
	end

	// ----------------------------------------------------------------------
	// Bus tracking

	assign data_live = mem_data_vld && flush_ctr == 2'd0;
	assign data_hwvld = dph_hwvld;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= 2'd0;
			flush_ctr <= 2'd0;
		end else begin
			pending <= pending + pending_t'(addr_accept) - pending_t'(mem_data_vld);
			// Every fetch still out at the jump belongs to the old stream
			if (jump_now) begin
				flush_ctr <= pending - pending_t'(mem_data_vld);
			end else if (flush_ctr != 2'd0 && mem_data_vld) begin
				flush_ctr <= flush_ctr - 2'd1;
			end
		end
	end

	// After a jump to an odd halfword only the upper half of the target word
	// is wanted. That word is always the first live return after the jump
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			aph_hwvld <= 2'b11;
			dph_hwvld <= 2'b11;
		end else if (jump_now) begin
			if (addr_accept) begin
				aph_hwvld <= 2'b11;
				dph_hwvld <= {1'b1, !jump_target[1]};
			end else begin
				aph_hwvld <= {1'b1, !jump_target[1]};
				dph_hwvld <= 2'b11;
			end
		end else begin
			if (addr_accept) begin
				aph_hwvld <= 2'b11;
			end
			if (addr_accept && !aph_hwvld[0]) begin
				dph_hwvld <= aph_hwvld;
			end else if (data_live) begin
				dph_hwvld <= 2'b11;
			end
		end
	end

	// Never more than two fetches outstanding on the bus
	assert property (@(posedge clk) disable iff (!rst_n) pending <= 2'd2)
		else $error("more than two fetches in flight");

	// Only fetches that were really issued can be flushed
	assert property (@(posedge clk) disable iff (!rst_n) flush_ctr <= pending)
		else $error("flush count exceeds pending fetches");

	// The memory must not return data that nobody asked for
	assert property (@(posedge clk) disable iff (!rst_n) mem_data_vld |-> pending != 2'd0)
		else $error("data strobe with no fetch pending");

endmodule

`default_nettype wire

// ==== design/fetch_queue.sv ====
/* Second front-end stage. A compact shift queue of fetched words with their
   halfword masks and error flags, bypassed when empty */

`default_nettype none

module fetch_queue #(
	parameter int QUEUE_DEPTH = frontend_pkg::DEFAULT_QUEUE_DEPTH
) (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire frontend_pkg::word_t     mem_data,
	input  wire                          mem_data_err,
	input  wire                          data_live,
	input  wire frontend_pkg::hw_mask_t  data_hwvld,
	input  wire                          jump_now,
	input  wire                          cir_room,
	output logic                         queue_full,
	output logic                         queue_almost_full,
	output logic                         fetch_vld,
	output frontend_pkg::word_t          fetch_data,
	output frontend_pkg::hw_mask_t       fetch_hwvld,
	output logic                         fetch_err
);

	import frontend_pkg::*;

	// Entry 0 is the head, entries fill upward from there
	word_t                  q_data [QUEUE_DEPTH];
	logic                   q_err [QUEUE_DEPTH];
	hw_mask_t               q_hw [QUEUE_DEPTH];
	// Each entry's upper neighbour, which moves into it on a pop
	word_t                  up_data [QUEUE_DEPTH];
	logic                   up_err [QUEUE_DEPTH];
	hw_mask_t               up_hw [QUEUE_DEPTH];
	logic [QUEUE_DEPTH-1:0] q_vld;
	logic [QUEUE_DEPTH-1:0] vld_above;
	logic [QUEUE_DEPTH-1:0] vld_below;
	logic                   q_empty;
	logic                   push;
	logic                   pop;

	if (QUEUE_DEPTH < 2) begin : g_depth_check
		$error("fetch_queue needs at least two entries");
	end

	always_comb begin
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			q_vld[i] = |q_hw[i];
		end
		for (int i = 0; i < QUEUE_DEPTH - 1; i++) begin
			up_data[i] = q_data[i + 1];
			up_err[i] = q_err[i + 1];
			up_hw[i] = q_hw[i + 1];
		end
		// The top entry has nothing above it and refills from the bus
		up_data[QUEUE_DEPTH - 1] = mem_data;
		up_err[QUEUE_DEPTH - 1] = mem_data_err;
		up_hw[QUEUE_DEPTH - 1] = 2'b00;
	end

	assign vld_above = {1'b0, q_vld[QUEUE_DEPTH-1:1]};
	assign vld_below = {q_vld[QUEUE_DEPTH-2:0], 1'b1};

	assign q_empty = !q_vld[0];
	assign queue_full = q_vld[QUEUE_DEPTH - 1];
	assign queue_almost_full = q_vld[QUEUE_DEPTH - 2];

	// Live data skips the queue when it is empty and CIR can take it now
	assign pop = cir_room && !q_empty;
	assign push = data_live && !(cir_room && q_empty);

	// Payload moves with the masks. Stale words sit under a zero mask
	always_ff @(posedge clk) begin
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			if (pop || (push && !q_vld[i])) begin
				q_data[i] <= vld_above[i] ? up_data[i] : mem_data;
				q_err[i] <= vld_above[i] ? up_err[i] : mem_data_err;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < QUEUE_DEPTH; i++) begin
				q_hw[i] <= 2'b00;
			end
		end else begin
			for (int i = 0; i < QUEUE_DEPTH; i++) begin
				if (jump_now) begin
					q_hw[i] <= 2'b00;
				end else if (pop && vld_above[i]) begin
					q_hw[i] <= up_hw[i];
				end else if (pop && q_vld[i]) begin
					// Topmost valid entry after a pop takes the new word, if any
					q_hw[i] <= push ? data_hwvld : 2'b00;
				end else if (push && !pop && !q_vld[i] && vld_below[i]) begin
					q_hw[i] <= data_hwvld;
				end
			end
		end
	end

	// Head of the queue, or the bus itself when the queue is empty
	assign fetch_vld = !q_empty || data_live;
	assign fetch_data = q_empty ? mem_data : q_data[0];
	assign fetch_hwvld = q_empty ? data_hwvld : q_hw[0];
	assign fetch_err = q_empty ? mem_data_err : q_err[0];

	// Valid entries always form an unbroken run from the head
	assert property (@(posedge clk) disable iff (!rst_n) (q_vld & ~vld_below) == '0)
		else $error("prefetch queue is not compact");

endmodule

`default_nettype wire

// ==== design/instr_assembly.sv ====
/* Third front-end stage. Aligns fetched halfwords into the current instruction
   register for decode and keeps one spare halfword plus per-halfword errors */

`default_nettype none

module instr_assembly (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          fetch_vld,
	input  wire frontend_pkg::word_t     fetch_data,
	input  wire frontend_pkg::hw_mask_t  fetch_hwvld,
	input  wire                          fetch_err,
	input  wire frontend_pkg::level_t    cir_use,
	input  wire                          jump_now,
	output rv_isa_pkg::cir_t             cir,
	output frontend_pkg::level_t         cir_vld,
	output frontend_pkg::hw_mask_t       cir_err,
	output logic                         cir_room
);

	import frontend_pkg::*;
	import rv_isa_pkg::*;

	localparam int HW = $bits(halfword_t);

	// Third halfword that does not fit in CIR yet
	halfword_t         hwbuf;
	// Error flags for {hwbuf, cir upper, cir lower}
	logic [2:0]        buf_err;
	// Valid halfwords held in {hwbuf, cir}
	level_t            buf_level;
	level_t            level_after_use;
	level_t            fill_amount;
	level_t            level_next;
	logic              fill;
	halfword_t         fetch_lo;
	cir_t              fetch_aligned;
	logic [3*HW-1:0]   data_shifted;
	logic [3*HW-1:0]   data_next;
	logic [2:0]        err_shifted;
	logic [2:0]        err_next;

	// ----------------------------------------------------------------------
	// Consume

	// Remaining halfwords move down by what decode used
	// Slots above the new level get whatever is cheapest
	always_comb begin
		if (cir_use[1]) begin
			data_shifted = {hwbuf, cir[HW +: HW], hwbuf};
			err_shifted = buf_err >> 2;
		end else if (cir_use[0]) begin
			data_shifted = {hwbuf, hwbuf, cir[HW +: HW]};
			err_shifted = buf_err >> 1;
		end else begin
			data_shifted = {hwbuf, cir};
			err_shifted = buf_err;
		end
	end

	assign level_after_use = buf_level - cir_use;

	// ----------------------------------------------------------------------
	// Fill

	// Bring the upper halfword down when only that one is valid
	assign fetch_lo = fetch_hwvld[0] ? fetch_data[0 +: HW] : fetch_data[HW +: HW];
	assign fetch_aligned = {fetch_data[HW +: HW], fetch_lo};

	// A whole word fits over one remaining halfword, a half word over two
	assign cir_room = level_after_use <= ((fetch_hwvld == 2'b11) ? 2'd1 : 2'd2);
	assign fill = cir_room && fetch_vld;
	assign fill_amount = !fill ? 2'd0 : ((fetch_hwvld == 2'b11) ? 2'd2 : 2'd1);
	assign level_next = jump_now ? 2'd0 : level_after_use + fill_amount;

	// Lay the fetch word just above the halfwords that are kept
	always_comb begin
		if (!cir_room) begin
			data_next = data_shifted;
			err_next = err_shifted;
		end else begin
			case (level_after_use)
				2'd2: begin
					data_next = {fetch_aligned[0 +: HW], data_shifted[0 +: 2*HW]};
					err_next = {fetch_err, err_shifted[1:0]};
				end
				2'd1: begin
					data_next = {fetch_aligned, data_shifted[0 +: HW]};
					err_next = {{2{fetch_err}}, err_shifted[0]};
				end
				default: begin
					data_next = {data_shifted[2*HW +: HW], fetch_aligned};
					err_next = {err_shifted[2], {2{fetch_err}}};
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buf_level <= 2'd0;
			cir_vld <= 2'd0;
			buf_err <= 3'b000;
		end else begin
			buf_level <= level_next;
			// CIR shows at most two halfwords, the spare stays hidden
			cir_vld <= (level_next > 2'd2) ? 2'd2 : level_next;
			buf_err <= jump_now ? 3'b000 : err_next;
		end
	end

	always_ff @(posedge clk) begin
		{hwbuf, cir} <= data_next;
	end

	assign cir_err = buf_err[1:0];

	// Decode may only consume what CIR presents
	assert property (@(posedge clk) disable iff (!rst_n) cir_use <= cir_vld)
		else $error("decode consumed more halfwords than valid");

	// At most two halfwords arrive per cycle, so 0 to 3 can only be an underflow
	assert property (@(posedge clk) disable iff (!rst_n) buf_level == 2'd0 |=> buf_level != 2'd3)
		else $error("assembly buffer level wrapped below zero");

endmodule

`default_nettype wire

// ==== design/fetch_frontend.sv ====
/* Top of the instruction fetch front end. Chains fetch request, prefetch
   queue and instruction assembly between the memory bus and decode */

`default_nettype none

module fetch_frontend #(
	parameter frontend_pkg::addr_t RESET_VECTOR = frontend_pkg::DEFAULT_RESET_VECTOR,
	parameter int QUEUE_DEPTH = frontend_pkg::DEFAULT_QUEUE_DEPTH
) (
	input  wire                          clk,
	input  wire                          rst_n,
	// Memory address and data ports
	output frontend_pkg::addr_t          mem_addr,
	output logic                         mem_addr_vld,
	input  wire                          mem_addr_rdy,
	input  wire frontend_pkg::word_t     mem_data,
	input  wire                          mem_data_err,
	input  wire                          mem_data_vld,
	// Jump requests from the core
	input  wire frontend_pkg::addr_t     jump_target,
	input  wire                          jump_target_vld,
	output logic                         jump_target_rdy,
	// Decode port
	output rv_isa_pkg::cir_t             cir,
	output frontend_pkg::level_t         cir_vld,
	output frontend_pkg::hw_mask_t       cir_err,
	input  wire frontend_pkg::level_t    cir_use
);

	import frontend_pkg::*;

	logic     jump_now;
	logic     data_live;
	hw_mask_t data_hwvld;
	logic     queue_full;
	logic     queue_almost_full;
	logic     fetch_vld;
	word_t    fetch_data;
	hw_mask_t fetch_hwvld;
	logic     fetch_err;
	logic     cir_room;

	fetch_request #(
		.RESET_VECTOR(RESET_VECTOR)
	) u_fetch_request (
		.clk(clk),
		.rst_n(rst_n),
		.mem_addr_rdy(mem_addr_rdy),
		.mem_data_vld(mem_data_vld),
		.jump_target(jump_target),
		.jump_target_vld(jump_target_vld),
		.queue_full(queue_full),
		.queue_almost_full(queue_almost_full),
		.mem_addr(mem_addr),
		.mem_addr_vld(mem_addr_vld),
		.jump_target_rdy(jump_target_rdy),
		.jump_now(jump_now),
		.data_live(data_live),
		.data_hwvld(data_hwvld)
	);

	fetch_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_fetch_queue (
		.clk(clk),
		.rst_n(rst_n),
		.mem_data(mem_data),
		.mem_data_err(mem_data_err),
		.data_live(data_live),
		.data_hwvld(data_hwvld),
		.jump_now(jump_now),
		.cir_room(cir_room),
		.queue_full(queue_full),
		.queue_almost_full(queue_almost_full),
		.fetch_vld(fetch_vld),
		.fetch_data(fetch_data),
		.fetch_hwvld(fetch_hwvld),
		.fetch_err(fetch_err)
	);

	instr_assembly u_instr_assembly (
		.clk(clk),
		.rst_n(rst_n),
		.fetch_vld(fetch_vld),
		.fetch_data(fetch_data),
		.fetch_hwvld(fetch_hwvld),
		.fetch_err(fetch_err),
		.cir_use(cir_use),
		.jump_now(jump_now),
		.cir(cir),
		.cir_vld(cir_vld),
		.cir_err(cir_err),
		.cir_room(cir_room)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_models.svh ====
/* Memory model, data and error rules and the expected-stream model of the
   fetch front-end testbench. Included inside the testbench module body */

`ifndef TB_MODELS_SVH
`define TB_MODELS_SVH

// ----------------------------------------------------------------------
// Data and error rules

// Word content is a fixed hash of the word address
// The two low bits of each parcel copy one hash bit, so about half start a 32-bit instruction
function automatic word_t word_at(addr_t addr);
	logic [31:0] wa;
	logic [31:0] mix;
	wa = {addr[31:2], 2'b00};
	mix = (wa * 32'h9e37_79b1) ^ (wa >> 5) ^ 32'h5a3c_96e1;
	return {mix[31:18], {2{mix[7]}}, mix[15:2], {2{mix[27]}}};
endfunction

// Bus error on every word whose address bits 7:6 are both set
function automatic logic err_at(addr_t addr);
	return addr[7:6] == 2'b11;
endfunction

// Parcel at a halfword aligned byte address
function automatic halfword_t parcel_at(addr_t addr);
	word_t w;
	w = word_at(addr);
	return addr[1] ? w[31:16] : w[15:0];
endfunction

// Instruction length in halfwords for a parcel starting at addr
function automatic level_t len_at(addr_t addr);
	halfword_t p;
	p = parcel_at(addr);
	return (p[1:0] == LEN32_CODE) ? 2'd2 : 2'd1;
endfunction

// ----------------------------------------------------------------------
// Memory model

// Accepted word addresses whose data has not been returned yet, oldest first
addr_t mem_pending[$];

// Called on the rising edge, ready is random and the oldest fetch may return
task automatic drive_memory();
	addr_t a;
	mem_addr_rdy <= ($urandom_range(0, 3) != 0);
	if (mem_pending.size() > 0 && $urandom_range(0, 1) == 1) begin
		a = mem_pending.pop_front();
		mem_data <= word_at(a);
		mem_data_err <= err_at(a);
		mem_data_vld <= 1'b1;
	end else begin
		// Idle data lines carry junk that must never reach decode
		mem_data <= $urandom();
		mem_data_err <= 1'($urandom_range(0, 1));
		mem_data_vld <= 1'b0;
	end
endtask

// An accepted address is queued; at most two may wait for data
task automatic accept_fetch(addr_t addr);
	mem_pending.push_back(addr);
	assert (mem_pending.size() <= 2) else begin
		$display("More than two fetches were accepted without returning data");
		bus_errors++;
	end
endtask

// ----------------------------------------------------------------------
// Expected stream

// Compares one consumed CIR slot with the parcel at the expected address
task automatic check_parcel(int slot);
	assert (cir[16*slot +: 16] == parcel_at(exp_addr)) else begin
		$display("Fail cir[%0d]: got %h expected %h at address %h",
			slot, cir[16*slot +: 16], parcel_at(exp_addr), exp_addr);
		data_errors++;
	end
	assert (cir_err[slot] == err_at(exp_addr)) else begin
		$display("Fail cir_err[%0d]: got %h expected %h at address %h",
			slot, cir_err[slot], err_at(exp_addr), exp_addr);
		flag_errors++;
	end
	exp_addr = exp_addr + 32'd2;
endtask

`endif

// ==== testbench/tb_fetch_frontend.sv ====
/* Testbench of the fetch front end. Random memory latency, jumps and decode
   stalls, with every consumed halfword checked against the data rule */

`default_nettype none

module tb_fetch_frontend;

	import frontend_pkg::*;
	import rv_isa_pkg::*;

	localparam addr_t START_ADDR = 32'h0000_0180;
	localparam int SEED = 25276;
	localparam int RUN_CYCLES = 8000;
	localparam int ADDR_TIMEOUT = 50;
	localparam int PROGRESS_TIMEOUT = 400;

	logic     clk;
	logic     rst_n;
	logic     mem_addr_rdy;
	word_t    mem_data;
	logic     mem_data_err;
	logic     mem_data_vld;
	addr_t    jump_target;
	logic     jump_target_vld;
	level_t   cir_use;
	addr_t    mem_addr;
	logic     mem_addr_vld;
	logic     jump_target_rdy;
	cir_t     cir;
	level_t   cir_vld;
	hw_mask_t cir_err;

	int       data_errors;
	int       flag_errors;
	int       bus_errors;
	// Address of the next halfword decode should receive
	addr_t    exp_addr;
	// What was seen in the cycle just ended
	level_t   vld_seen;
	level_t   use_seen;
	logic     jump_seen;
	logic     hold_seen;
	addr_t    addr_seen;
	logic     first_fetch_seen;
	int       stall_left;
	int       idle_cycles;
	logic     timed_out;

	`include "tb_models.svh"

	fetch_frontend #(
		.RESET_VECTOR(START_ADDR),
		.QUEUE_DEPTH(2)
	) dut (
		.clk(clk),
		.rst_n(rst_n),
		.mem_addr(mem_addr),
		.mem_addr_vld(mem_addr_vld),
		.mem_addr_rdy(mem_addr_rdy),
		.mem_data(mem_data),
		.mem_data_err(mem_data_err),
		.mem_data_vld(mem_data_vld),
		.jump_target(jump_target),
		.jump_target_vld(jump_target_vld),
		.jump_target_rdy(jump_target_rdy),
		.cir(cir),
		.cir_vld(cir_vld),
		.cir_err(cir_err),
		.cir_use(cir_use)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// Stimulus on the rising edge

	task automatic drive_inputs();
		level_t avail;
		level_t len;
		drive_memory();
		// CIR never shrinks except by decode or a jump, so this is a safe lower bound
		avail = jump_seen ? 2'd0 : level_t'(vld_seen - use_seen);
		len = len_at(exp_addr);
		if (stall_left > 0) begin
			stall_left--;
			cir_use <= 2'd0;
		end else begin
			if ($urandom_range(0, 149) == 0) begin
				stall_left = $urandom_range(20, 60);
			end
			cir_use <= (avail >= len && $urandom_range(0, 2) != 0) ? len : 2'd0;
		end
		// A jump request stays up until it is taken
		if (jump_seen) begin
			jump_target_vld <= 1'b0;
		end else if (!jump_target_vld && first_fetch_seen && $urandom_range(0, 39) == 0) begin
			jump_target_vld <= 1'b1;
			jump_target <= {22'd0, 9'($urandom_range(0, 511)), 1'b0};
		end
	endtask

	// ----------------------------------------------------------------------
	// Checks on the falling edge, where every output has settled

	task automatic sample_outputs();
		// A jump is refused only while an address waits on the bus
		assert (jump_target_rdy == !hold_seen) else begin
			$display("Fail jump_target_rdy: got %h expected %h",
				jump_target_rdy, !hold_seen);
			bus_errors++;
		end
		if (hold_seen) begin
			assert (mem_addr_vld && mem_addr == addr_seen) else begin
				$display("Fail mem_addr: got %h valid %h, expected %h held",
					mem_addr, mem_addr_vld, addr_seen);
				bus_errors++;
			end
		end
		if (mem_addr_vld) begin
			assert (mem_addr[1:0] == 2'b00) else begin
				$display("Fail mem_addr: got %h, expected a word aligned address", mem_addr);
				bus_errors++;
			end
		end
		if (jump_seen) begin
			assert (cir_vld == 2'd0) else begin
				$display("Fail cir_vld after jump: got %h expected 0", cir_vld);
				bus_errors++;
			end
		end
		if (mem_addr_vld && mem_addr_rdy) begin
			if (!first_fetch_seen) begin
				assert (mem_addr == START_ADDR) else begin
					$display("Fail mem_addr: got %h expected %h", mem_addr, START_ADDR);
					bus_errors++;
				end
			end
			first_fetch_seen = 1'b1;
			accept_fetch(mem_addr);
		end
		// The older parcel sits in the low half of CIR
		if (cir_use != 2'd0) begin
			check_parcel(0);
			idle_cycles = 0;
		end else begin
			idle_cycles++;
		end
		if (cir_use == 2'd2) begin
			check_parcel(1);
		end
		jump_seen = jump_target_vld && jump_target_rdy;
		if (jump_seen) begin
			exp_addr = jump_target;
		end
		vld_seen = cir_vld;
		use_seen = cir_use;
		hold_seen = mem_addr_vld && !mem_addr_rdy;
		addr_seen = mem_addr;
	endtask

	task automatic step_cycle();
		@(posedge clk);
		drive_inputs();
		@(negedge clk);
		sample_outputs();
	endtask

	initial begin
		void'($urandom(SEED));
		rst_n = 1'b0;
		mem_addr_rdy = 1'b0;
		mem_data = '0;
		mem_data_err = 1'b0;
		mem_data_vld = 1'b0;
		jump_target = '0;
		jump_target_vld = 1'b0;
		cir_use = 2'd0;
		data_errors = 0;
		flag_errors = 0;
		bus_errors = 0;
		exp_addr = START_ADDR;
		vld_seen = 2'd0;
		use_seen = 2'd0;
		jump_seen = 1'b0;
		hold_seen = 1'b0;
		addr_seen = '0;
		first_fetch_seen = 1'b0;
		stall_left = 0;
		idle_cycles = 0;
		timed_out = 1'b0;

		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		// First cycle out of reset is the hold-off cycle
		@(negedge clk);
		assert (!mem_addr_vld) else begin
			$display("Fail mem_addr_vld: got %h expected 0 in the hold-off cycle", mem_addr_vld);
			bus_errors++;
		end

		for (int i = 0; i < ADDR_TIMEOUT && !first_fetch_seen; i++) begin
			step_cycle();
		end
		if (!first_fetch_seen) begin
			$display("Timeout: no fetch address was accepted after reset");
			timed_out = 1'b1;
		end

		for (int i = 0; i < RUN_CYCLES && !timed_out; i++) begin
			step_cycle();
			if (idle_cycles > PROGRESS_TIMEOUT) begin
				$display("Timeout: decode received no instruction for %0d cycles", idle_cycles);
				timed_out = 1'b1;
			end
		end

		$display("Errors: data %0d, error flags %0d, bus %0d, timeout %0d",
			data_errors, flag_errors, bus_errors, timed_out);
		if (!timed_out && data_errors + flag_errors + bus_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+testbench
design/frontend_pkg.sv
design/rv_isa_pkg.sv
design/fetch_request.sv
design/fetch_queue.sv
design/instr_assembly.sv
design/fetch_frontend.sv
testbench/tb_fetch_frontend.sv

// ==== run.sh ====
#!/bin/sh
# Builds the fetch front-end testbench with Verilator and runs it.
# The exit status is zero only when the simulation prints its pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal -f sources.f \
	--top-module tb_fetch_frontend -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -q "=== PASS ===" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
